// File: design/ttc_apb_regs.sv
`timescale 1ns/1ps

module ttc_apb_regs import ttc_pkg::*; (
   input  logic                         pclk,
   input  logic                         rst,
   input  logic                         psel,
   input  logic                         penable,
   input  logic                         pwrite,
   input  bus_addr_t                    paddr,
   input  timer_regs_t [NUM_TIMERS:1]   regs,       // Readback from the timers
   output bus_data_t                    prdata,
   output timer_sel_t  [NUM_TIMERS:1]   sel,        // Write strobes per timer
   output logic        [NUM_TIMERS:1]   clear_irq   // IRQ read, clear pulse
);

   logic      wr_access;   // Write access phase
   logic      rd_access;   // Read access phase
   logic      rd_setup;    // Read setup phase, capture edge
   bus_data_t rd_mux;

   // Address of timer t within a register group
   function automatic logic hit(bus_addr_t addr, bus_addr_t base, int t);
      bus_addr_t target;
      target = base + bus_addr_t'(TIMER_STRIDE * (t - 1));
      return addr == target;
   endfunction

   assign wr_access = psel & penable & pwrite;
   assign rd_access = psel & penable & ~pwrite;
   assign rd_setup  = psel & ~penable & ~pwrite;

   //--------------------------------------------------------------------------
   // Write selects and clear-on-read
   //--------------------------------------------------------------------------
   always_comb begin
      sel       = '0;
      clear_irq = '0;
      for (int t = 1; t <= NUM_TIMERS; t++) begin
         sel[t].clk_ctrl  = wr_access & hit(paddr, CLK_CTRL_OFS, t);
         sel[t].cntr_ctrl = wr_access & hit(paddr, CNTR_CTRL_OFS, t);
         sel[t].interval  = wr_access & hit(paddr, INTERVAL_OFS, t);
         sel[t].match1    = wr_access & hit(paddr, MATCH1_OFS, t);
         sel[t].match2    = wr_access & hit(paddr, MATCH2_OFS, t);
         sel[t].match3    = wr_access & hit(paddr, MATCH3_OFS, t);
         sel[t].irq_en    = wr_access & hit(paddr, IRQ_EN_OFS, t);
         clear_irq[t]     = rd_access & hit(paddr, IRQ_OFS, t);  // Counter value is read-only
      end
   end

   //--------------------------------------------------------------------------
   // Read mux, zero-extended, unmapped addresses give zero
   //--------------------------------------------------------------------------
   always_comb begin
      rd_mux = '0;
      for (int t = 1; t <= NUM_TIMERS; t++) begin
         if (hit(paddr, CLK_CTRL_OFS, t)) begin
            rd_mux = bus_data_t'(regs[t].clk_ctrl);
         end else if (hit(paddr, CNTR_CTRL_OFS, t)) begin
            rd_mux = bus_data_t'(regs[t].cntr_ctrl);
         end else if (hit(paddr, COUNTER_VAL_OFS, t)) begin
            rd_mux = bus_data_t'(regs[t].counter_val);
         end else if (hit(paddr, INTERVAL_OFS, t)) begin
            rd_mux = bus_data_t'(regs[t].interval);
         end else if (hit(paddr, MATCH1_OFS, t)) begin
            rd_mux = bus_data_t'(regs[t].match1);
         end else if (hit(paddr, MATCH2_OFS, t)) begin
            rd_mux = bus_data_t'(regs[t].match2);
         end else if (hit(paddr, MATCH3_OFS, t)) begin
            rd_mux = bus_data_t'(regs[t].match3);
         end else if (hit(paddr, IRQ_OFS, t)) begin
            rd_mux = bus_data_t'(regs[t].irq);
         end else if (hit(paddr, IRQ_EN_OFS, t)) begin
            rd_mux = bus_data_t'(regs[t].irq_en);
         end
      end
   end

   // Captured at the setup edge, stable through the access phase
   always_ff @(posedge pclk) begin
      if (rst) begin
         prdata <= '0;
      end else if (rd_setup) begin
         prdata <= rd_mux;
      end
   end

endmodule

// File: design/ttc_counter.sv
`timescale 1ns/1ps

module ttc_counter import ttc_pkg::*; (
   input  logic        pclk,
   input  logic        rst,
   input  ttc_data_t   pwdata,      // Low half of the bus write data
   input  timer_sel_t  sel,
   input  logic        clear_irq,
   output timer_regs_t regs,
   output logic        interrupt
);

   timer_regs_t r;              // All software-visible state
   logic        tick;
   logic        advance;        // Counting edge
   logic        count_up;
   logic        int_mode;       // Interval, else free-run
   logic        wrap;
   logic        load_strobe;    // Counter reset strobe written
   ttc_data_t   load_val;
   ttc_data_t   cnt_next;
   ttc_irq_t    irq_set;

   ttc_prescaler u_prescaler (
      .pclk        (pclk),
      .rst         (rst),
      .clk_ctrl    (r.clk_ctrl),
      .clk_ctrl_wr (sel.clk_ctrl),
      .tick        (tick)
   );

   //--------------------------------------------------------------------------
   // Next count and wrap detection
   //--------------------------------------------------------------------------
   assign advance  = tick & ~r.cntr_ctrl[CNT_DISABLE_BIT];
   assign count_up = ~r.cntr_ctrl[CNT_DECREMENT_BIT];
   assign int_mode = r.cntr_ctrl[CNT_INTERVAL_BIT];

   always_comb begin
      wrap     = 1'b0;
      cnt_next = r.counter_val;
      if (count_up) begin
         if (int_mode && r.counter_val >= r.interval) begin
            cnt_next = '0;                // Interval reached
            wrap     = 1'b1;
         end else begin
            cnt_next = r.counter_val + ttc_data_t'(1);
            wrap     = &r.counter_val;    // Free-run overflow
         end
      end else begin
         if (r.counter_val == '0) begin
            cnt_next = int_mode ? r.interval : '1;
            wrap     = 1'b1;
         end else begin
            cnt_next = r.counter_val - ttc_data_t'(1);
         end
      end
   end

   // Reset strobe load value follows the mode being written
   assign load_strobe = sel.cntr_ctrl & pwdata[CNT_RESET_BIT];
   assign load_val    = !pwdata[CNT_DECREMENT_BIT] ? '0 :
                        pwdata[CNT_INTERVAL_BIT] ? r.interval : '1;

   //--------------------------------------------------------------------------
   // Interrupt sources
   //--------------------------------------------------------------------------
   always_comb begin
      irq_set                   = '0;
      irq_set[IRQ_INTERVAL_BIT] = advance & wrap & int_mode;
      irq_set[IRQ_OVERFLOW_BIT] = advance & wrap & ~int_mode;
      if (advance && r.cntr_ctrl[CNT_MATCH_EN_BIT]) begin
         irq_set[IRQ_MATCH1_BIT] = (cnt_next == r.match1);
         irq_set[IRQ_MATCH2_BIT] = (cnt_next == r.match2);
         irq_set[IRQ_MATCH3_BIT] = (cnt_next == r.match3);
      end
   end

   //--------------------------------------------------------------------------
   // Registers
   //--------------------------------------------------------------------------
   always_ff @(posedge pclk) begin
      if (rst) begin
         r           <= '0;
         r.cntr_ctrl <= CNTR_CTRL_RST;   // Start disabled
         interrupt   <= 1'b0;
      end else begin
         if (sel.clk_ctrl)  r.clk_ctrl  <= pwdata[CTRL_W-1:0] & CLK_CTRL_MASK;
         if (sel.cntr_ctrl) r.cntr_ctrl <= pwdata[CTRL_W-1:0] & CNTR_CTRL_MASK;
         if (sel.interval)  r.interval  <= pwdata;
         if (sel.match1)    r.match1    <= pwdata;
         if (sel.match2)    r.match2    <= pwdata;
         if (sel.match3)    r.match3    <= pwdata;
         if (sel.irq_en)    r.irq_en    <= pwdata[IRQ_W-1:0] & IRQ_MASK;

         if (load_strobe) begin
            r.counter_val <= load_val;   // Strobe wins over counting
         end else if (advance) begin
            r.counter_val <= cnt_next;
         end

         // Sticky, a new event on the clear edge survives
         r.irq     <= (clear_irq ? '0 : r.irq) | irq_set;
         interrupt <= |(r.irq & r.irq_en);
      end
   end

   assign regs = r;

endmodule

// File: design/ttc_lite.sv
`timescale 1ns/1ps

module ttc_lite import ttc_pkg::*; (
   input  logic                  pclk,
   input  logic                  rst,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  bus_addr_t             paddr,
   input  bus_data_t             pwdata,
   output bus_data_t             prdata,
   output logic [NUM_TIMERS:1]   interrupt   // One line per timer
);

   //--------------------------------------------------------------------------
   // Interconnect
   //--------------------------------------------------------------------------
   timer_regs_t [NUM_TIMERS:1] regs;       // Timer state for readback
   timer_sel_t  [NUM_TIMERS:1] sel;        // Write strobes
   logic        [NUM_TIMERS:1] clear_irq;

   ttc_apb_regs u_regs (
      .pclk      (pclk),
      .rst       (rst),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .regs      (regs),
      .prdata    (prdata),
      .sel       (sel),
      .clear_irq (clear_irq)
   );

   // Timers 1 to 3, only the low half of write data is used
   for (genvar t = 1; t <= NUM_TIMERS; t++) begin : g_timer
      ttc_counter u_timer (
         .pclk      (pclk),
         .rst       (rst),
         .pwdata    (pwdata[DATA_W-1:0]),
         .sel       (sel[t]),
         .clear_irq (clear_irq[t]),
         .regs      (regs[t]),
         .interrupt (interrupt[t])
      );
   end

endmodule

// File: design/ttc_pkg.sv
package ttc_pkg;

   //--------------------------------------------------------------------------
   // Widths and base types
   //--------------------------------------------------------------------------
   localparam int DATA_W     = 16;     // Counter, interval, match
   localparam int CTRL_W     = 7;      // Clock and counter control
   localparam int IRQ_W      = 6;      // Interrupt and enable
   localparam int NUM_TIMERS = 3;

   typedef logic [DATA_W-1:0] ttc_data_t;
   typedef logic [CTRL_W-1:0] ttc_ctrl_t;
   typedef logic [IRQ_W-1:0]  ttc_irq_t;
   typedef logic [7:0]        bus_addr_t;
   typedef logic [31:0]       bus_data_t;

   //--------------------------------------------------------------------------
   // Register map, one group of three words per register kind
   //--------------------------------------------------------------------------
   localparam bus_addr_t CLK_CTRL_OFS    = 8'h00;
   localparam bus_addr_t CNTR_CTRL_OFS   = 8'h0C;
   localparam bus_addr_t COUNTER_VAL_OFS = 8'h18;
   localparam bus_addr_t INTERVAL_OFS    = 8'h24;
   localparam bus_addr_t MATCH1_OFS      = 8'h30;
   localparam bus_addr_t MATCH2_OFS      = 8'h3C;
   localparam bus_addr_t MATCH3_OFS      = 8'h48;
   localparam bus_addr_t IRQ_OFS         = 8'h54;
   localparam bus_addr_t IRQ_EN_OFS      = 8'h60;
   localparam bus_addr_t TIMER_STRIDE    = 8'h04;  // Timer n at +4*(n-1)

   // Clock control fields
   localparam int CLK_PRESCALE_EN_BIT = 0;
   localparam int CLK_PRESCALE_LSB    = 1;  // Exponent k
   localparam int CLK_PRESCALE_MSB    = 4;

   // Counter control fields
   localparam int CNT_DISABLE_BIT   = 0;
   localparam int CNT_INTERVAL_BIT  = 1;
   localparam int CNT_DECREMENT_BIT = 2;
   localparam int CNT_MATCH_EN_BIT  = 3;
   localparam int CNT_RESET_BIT     = 4;  // Strobe, never stored

   // Interrupt bits
   localparam int IRQ_INTERVAL_BIT = 0;
   localparam int IRQ_MATCH1_BIT   = 1;
   localparam int IRQ_MATCH2_BIT   = 2;
   localparam int IRQ_MATCH3_BIT   = 3;
   localparam int IRQ_OVERFLOW_BIT = 4;

   // Storable bits and reset values
   localparam ttc_ctrl_t CLK_CTRL_MASK  = 7'h1F;
   localparam ttc_ctrl_t CNTR_CTRL_MASK = 7'h0F;
   localparam ttc_ctrl_t CNTR_CTRL_RST  = 7'h01;  // Disabled
   localparam ttc_irq_t  IRQ_MASK       = 6'h1F;

   //--------------------------------------------------------------------------
   // Per-timer bundles between decoder and timers
   //--------------------------------------------------------------------------
   typedef struct packed {
      logic clk_ctrl;
      logic cntr_ctrl;
      logic interval;
      logic match1;
      logic match2;
      logic match3;
      logic irq_en;
   } timer_sel_t;

   typedef struct packed {
      ttc_ctrl_t clk_ctrl;
      ttc_ctrl_t cntr_ctrl;
      ttc_data_t counter_val;
      ttc_data_t interval;
      ttc_data_t match1;
      ttc_data_t match2;
      ttc_data_t match3;
      ttc_irq_t  irq;
      ttc_irq_t  irq_en;
   } timer_regs_t;

endpackage

// File: design/ttc_prescaler.sv
`timescale 1ns/1ps

module ttc_prescaler import ttc_pkg::*; (
   input  logic      pclk,
   input  logic      rst,
   input  ttc_ctrl_t clk_ctrl,
   input  logic      clk_ctrl_wr,   // Restarts the divider
   output logic      tick
);

   logic                               presc_en;
   logic [CLK_PRESCALE_MSB-CLK_PRESCALE_LSB:0] exp_k;
   logic [DATA_W-1:0]                  div_cnt;
   logic [DATA_W-1:0]                  div_last;   // 2^(k+1)-1

   assign presc_en = clk_ctrl[CLK_PRESCALE_EN_BIT];
   assign exp_k    = clk_ctrl[CLK_PRESCALE_MSB:CLK_PRESCALE_LSB];
   assign div_last = (DATA_W'(2) << exp_k) - DATA_W'(1);  // k=15 wraps to all ones

   // Free-running divider, parked at zero when bypassed
   always_ff @(posedge pclk) begin
      if (rst) begin
         div_cnt <= '0;
      end else if (clk_ctrl_wr || !presc_en) begin
         div_cnt <= '0;
      end else if (div_cnt == div_last) begin
         div_cnt <= '0;   // End of period
      end else begin
         div_cnt <= div_cnt + DATA_W'(1);
      end
   end

   assign tick = presc_en ? (div_cnt == div_last) : 1'b1;  // Bypass gives every cycle

endmodule

// File: ttc_lite.f
design/ttc_pkg.sv
design/ttc_apb_regs.sv
design/ttc_prescaler.sv
design/ttc_counter.sv
design/ttc_lite.sv
verification/ttc_lite_assertions.sv
verification/ttc_lite_tb.sv

// File: verification/ttc_lite_assertions.sv
`timescale 1ns/1ps

module ttc_lite_assertions import ttc_pkg::*; (
   input logic                pclk,
   input logic                rst,
   input logic                psel,
   input logic                penable,
   input logic [NUM_TIMERS:1] interrupt
);

   int fails = 0;   // Read by the testbench at the end

   // Access phase only inside a selected transfer
   a_penable_in_psel: assert property (@(posedge pclk) disable iff (rst) penable |-> psel)
      else begin
         $error("penable high without psel");
         fails++;
      end

   // Access phase lasts one cycle, no wait states
   a_penable_single: assert property (@(posedge pclk) disable iff (rst) penable |=> !penable)
      else begin
         $error("penable held high for two cycles");
         fails++;
      end

   a_irq_low_in_reset: assert property (@(posedge pclk) rst |=> interrupt == '0)
      else begin
         $error("interrupt active during reset");
         fails++;
      end

endmodule

bind ttc_lite ttc_lite_assertions u_assert (
   .pclk      (pclk),
   .rst       (rst),
   .psel      (psel),
   .penable   (penable),
   .interrupt (interrupt)
);

// File: verification/ttc_lite_tb.sv
`timescale 1ns/1ps

module ttc_lite_tb import ttc_pkg::*; ();

   logic                pclk;
   logic                rst;
   logic                psel;
   logic                penable;
   logic                pwrite;
   bus_addr_t           paddr;
   bus_data_t           pwdata;
   bus_data_t           prdata;
   logic [NUM_TIMERS:1] interrupt;

   int unsigned cycle = 0;     // Rising edges since start
   int unsigned wr_cycle;      // Edge of the last write access
   int          errors = 0;
   int          checks = 0;
   logic        check_pending = 1'b0;
   bus_data_t   exp_data;
   logic [31:0] rng = 32'hb395;
   bus_data_t   shadow [9][1:3];   // Last value written per register
   bus_addr_t   groups [9] = '{CLK_CTRL_OFS, CNTR_CTRL_OFS, COUNTER_VAL_OFS, INTERVAL_OFS,
                               MATCH1_OFS, MATCH2_OFS, MATCH3_OFS, IRQ_OFS, IRQ_EN_OFS};

   ttc_lite dut (
      .pclk      (pclk),
      .rst       (rst),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   initial pclk = 1'b0;
   always #5 pclk = ~pclk;
   always @(posedge pclk) cycle++;

   //--------------------------------------------------------------------------
   // Helpers
   //--------------------------------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic bus_addr_t reg_addr(input bus_addr_t grp, input int t);
      return grp + bus_addr_t'(4 * (t - 1));   // Timers one word apart
   endfunction

   // Readback of a written value per register group
   function automatic bus_data_t expected_read(input bus_addr_t grp, input bus_data_t wdata);
      case (grp)
         CLK_CTRL_OFS, IRQ_EN_OFS: return wdata & 32'h1F;   // Bits 5 and up read zero
         CNTR_CTRL_OFS:            return wdata & 32'h0F;   // Reset strobe not stored
         INTERVAL_OFS, MATCH1_OFS, MATCH2_OFS, MATCH3_OFS: return wdata & 32'hFFFF;
         default:                  return '0;
      endcase
   endfunction

   task automatic flag_error(input string what);
      $display("ERROR at %0t: %s", $time, what);
      errors++;
   endtask

   task automatic flag_mismatch(input string sig, input string expected,
                                input bus_data_t actual);
      $display("MISMATCH at %0t: %s expected %s actual %0h", $time, sig, expected, actual);
      errors++;
   endtask

   task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
      @(negedge pclk);
      psel    = 1'b1;   // Setup phase
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge pclk);
      penable = 1'b1;
      @(negedge pclk);
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      wr_cycle = cycle;   // Access edge just passed
   endtask

   task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
      @(negedge pclk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge pclk);
      penable = 1'b1;
      @(negedge pclk);
      data    = prdata;   // Held after the access phase
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic check_read(input bus_addr_t addr, input bus_data_t expected);
      bus_data_t unused;
      exp_data      = expected;
      check_pending = 1'b1;   // Compared in the access phase
      bus_read(addr, unused);
   endtask

   task automatic wait_irq(input int t, input int unsigned deadline);
      while (!interrupt[t] && cycle < deadline) @(negedge pclk);
      assert (interrupt[t]) else flag_error($sformatf("timer %0d interrupt did not rise", t));
   endtask

   // Read data compare
   always @(posedge pclk) begin
      if (psel && penable && !pwrite && check_pending) begin
         checks++;
         assert (prdata === exp_data) else begin
            $display("MISMATCH at %0t: prdata expected %08h actual %08h", $time, exp_data, prdata);
            errors++;
         end
         check_pending = 1'b0;
      end
   end

   // Six tests take under 2000 cycles, ten times that as the limit
   initial begin
      repeat (20000) @(posedge pclk);
      $display("Timeout, the tests did not finish within 20000 cycles");
      $display(">>> FAIL");
      $finish;
   end

   //--------------------------------------------------------------------------
   // Tests
   //--------------------------------------------------------------------------
   initial begin
      bus_data_t   rd;
      bus_data_t   wdata;
      int unsigned n;
      int unsigned k;
      int unsigned start;
      int unsigned exp_cnt;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (16) @(negedge pclk);
      rst = 1'b0;

      // Reset values, counter control starts disabled
      for (int t = 1; t <= NUM_TIMERS; t++)
         for (int g = 0; g < 9; g++)
            check_read(reg_addr(groups[g], t), (groups[g] == CNTR_CTRL_OFS) ? 32'h1 : 32'h0);
      assert (interrupt === '0) else flag_mismatch("interrupt", "0", interrupt);

      // Random register values, disable kept set
      for (int t = 1; t <= NUM_TIMERS; t++)
         for (int g = 0; g < 9; g++)
            if (groups[g] != COUNTER_VAL_OFS && groups[g] != IRQ_OFS) begin
               rng   = xorshift(rng);
               wdata = rng;
               if (groups[g] == CNTR_CTRL_OFS) wdata[0] = 1'b1;
               shadow[g][t] = wdata;
               bus_write(reg_addr(groups[g], t), wdata);
            end
      for (int t = 1; t <= NUM_TIMERS; t++)
         for (int g = 0; g < 9; g++)
            if (groups[g] != COUNTER_VAL_OFS)
               check_read(reg_addr(groups[g], t), expected_read(groups[g], shadow[g][t]));

      // Timer 1 interval mode
      rng = xorshift(rng);
      n   = 16 + rng[4:0];
      bus_write(reg_addr(CLK_CTRL_OFS, 1), 32'h0);
      bus_write(reg_addr(INTERVAL_OFS, 1), n);
      bus_write(reg_addr(IRQ_EN_OFS, 1), 32'h01);
      bus_write(reg_addr(CNTR_CTRL_OFS, 1), 32'h12);   // Interval, up, reset strobe
      wait_irq(1, wr_cycle + n + 4);
      // Reads three cycles apart, spanning more than one full period
      repeat (n / 3 + 2) begin
         bus_read(reg_addr(COUNTER_VAL_OFS, 1), rd);
         assert (rd <= n) else flag_mismatch("counter_val", $sformatf("<= %0h", n), rd);
      end
      bus_write(reg_addr(CNTR_CTRL_OFS, 1), 32'h03);   // Stopped before the clearing read
      check_read(reg_addr(IRQ_OFS, 1), 32'h01);
      check_read(reg_addr(IRQ_OFS, 1), 32'h0);

      // Timer 2 match 2, first with the enable, then masked
      rng = xorshift(rng);
      n   = 8 + rng[4:0];
      bus_write(reg_addr(CLK_CTRL_OFS, 2), 32'h0);
      bus_write(reg_addr(MATCH1_OFS, 2), 32'hFFFF);   // Out of reach
      bus_write(reg_addr(MATCH3_OFS, 2), 32'hFFFF);
      bus_write(reg_addr(MATCH2_OFS, 2), n);
      for (int pass = 0; pass < 2; pass++) begin
         bus_write(reg_addr(IRQ_EN_OFS, 2), (pass == 0) ? 32'h04 : 32'h0);
         bus_write(reg_addr(CNTR_CTRL_OFS, 2), 32'h18);   // Match enable, reset strobe
         if (pass == 0) begin
            wait_irq(2, wr_cycle + n + 4);
         end else begin
            repeat (n + 4) begin
               @(negedge pclk);
               assert (!interrupt[2]) else flag_mismatch("interrupt[2]", "0", interrupt[2]);
            end
         end
         check_read(reg_addr(IRQ_OFS, 2), 32'h04);
         bus_write(reg_addr(CNTR_CTRL_OFS, 2), 32'h01);
      end

      // Timer 3 prescaled count over a fixed window
      rng = xorshift(rng);
      k   = rng[1:0];
      bus_write(reg_addr(CLK_CTRL_OFS, 3), (k << 1) | 1);
      bus_write(reg_addr(CNTR_CTRL_OFS, 3), 32'h10);
      start = wr_cycle;
      repeat (200) @(negedge pclk);
      bus_write(reg_addr(CNTR_CTRL_OFS, 3), 32'h01);
      exp_cnt = (wr_cycle - start) >> (k + 1);   // One tick per 2^(k+1) edges
      bus_read(reg_addr(COUNTER_VAL_OFS, 3), rd);
      assert (rd + 1 >= exp_cnt && rd <= exp_cnt + 1)
         else flag_mismatch("counter_val", $sformatf("%0h +/- 1", exp_cnt), rd);
      check_read(reg_addr(COUNTER_VAL_OFS, 3), rd);
      check_read(reg_addr(COUNTER_VAL_OFS, 3), rd);

      // Timer 1 free-run decrement from the top
      bus_write(reg_addr(IRQ_EN_OFS, 1), 32'h10);
      bus_write(reg_addr(CNTR_CTRL_OFS, 1), 32'h15);   // Still disabled, loads FFFF
      check_read(reg_addr(COUNTER_VAL_OFS, 1), 32'hFFFF);
      bus_write(reg_addr(CNTR_CTRL_OFS, 1), 32'h04);
      repeat (50) @(negedge pclk);
      bus_read(reg_addr(COUNTER_VAL_OFS, 1), rd);
      assert (rd < 32'hFFFF) else flag_mismatch("counter_val", "< ffff", rd);
      check_read(reg_addr(IRQ_OFS, 1), 32'h0);   // No overflow before the wrap
      assert (!interrupt[1]) else flag_mismatch("interrupt[1]", "0", interrupt[1]);
      bus_write(reg_addr(CNTR_CTRL_OFS, 1), 32'h01);

      errors += dut.u_assert.fails;
      $display("Reads checked: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
